//--- sources.f
design/simple_processor_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/execution_unit.sv
design/core_controller.sv
design/simple_processor_top.sv
testbench/simple_processor_tb.sv

//--- Bender.yml
package:
  name: simple_processor

sources:
  - design/simple_processor_pkg.sv
  - design/instr_decoder.sv
  - design/register_file.sv
  - design/execution_unit.sv
  - design/core_controller.sv
  - design/simple_processor_top.sv
  - target: simulation
    files:
      - testbench/simple_processor_tb.sv

//--- testbench/simple_processor_testdata.txt
// Columns: instr(16) _ kind(1 result, 2 illegal, 3 result with stray strobe) _ rd _ value(32)
// Last line with kind 0 ends the list
2205_1_1_00000005 // ADDI r1, r0, 5
243D_1_2_FFFFFFFD // ADDI r2, r0, -3
261F_1_3_0000001F // ADDI r3, r0, 31
2820_1_4_FFFFFFE0 // ADDI r4, r0, -32
0A43_1_5_00000024 // ADD  r5, r1, r3
0A84_1_5_FFFFFFDD // ADD  r5, r2, r4 wraps
1C43_1_6_FFFFFFE6 // SUB  r6, r1, r3 borrows
1EC1_1_7_0000001A // SUB  r7, r3, r1
3A83_1_5_0000001D // AND  r5, r2, r3
4A47_1_5_0000001F // OR   r5, r1, r7
5B02_1_5_0000001D // XOR  r5, r4, r2
6AC2_1_5_FFFFFFE0 // NOT  r5, r3 with rs2 r2 ignored
6C07_1_6_FFFFFFFF // NOT  r6, r0
7A43_1_5_80000000 // SLL  r5, r1, r3 by 31
7A44_1_5_00000005 // SLL  r5, r1, r4 low bits zero
8A44_1_5_00000050 // SLLI r5, r1, 4
8A64_1_5_00000050 // SLLI r5, r1, 36 wraps to 4
9B83_1_5_00000001 // SLR  r5, r6, r3 zero fill
9A81_1_5_07FFFFFF // SLR  r5, r2, r1
AB04_1_5_0FFFFFFE // SLRI r5, r4, 4
ABBC_1_5_0000000F // SLRI r5, r6, 60 wraps to 28
2007_1_0_00000007 // ADDI r0, r0, 7 reported only
0A01_1_5_00000005 // ADD  r5, r0, r1 r0 still zero
B2C3_2_0_00000000 // Unused code 0xB, rd r1
0A40_1_5_00000005 // ADD  r5, r1, r0 r1 unchanged
F641_2_0_00000000 // Unused code 0xF, rd r3
0AC0_1_5_0000001F // ADD  r5, r3, r0 r3 unchanged
2E09_3_7_00000009 // ADDI r7, r0, 9 with stray ADDI r6
0B80_1_5_FFFFFFFF // ADD  r5, r6, r0 r6 unchanged
0BC0_1_5_00000009 // ADD  r5, r7, r0
0000_0_0_00000000

//--- testbench/simple_processor_tb.sv
`timescale 1ns/100ps
`default_nettype none

module simple_processor_tb;
  import simple_processor_pkg::*;

  localparam int unsigned MAX_VECTORS = 64;
  localparam int unsigned WAIT_LIMIT  = 50;      // Cycles before a wait gives up
  localparam logic [15:0] LFSR_SEED   = 16'd65;
  localparam instr_t      STRAY_INSTR = 16'h2C15; // ADDI r6, r0, 21

  // Vector kinds, column two of the data file
  localparam logic [3:0] KIND_END     = 4'd0;
  localparam logic [3:0] KIND_ILLEGAL = 4'd2;
  localparam logic [3:0] KIND_STRAY   = 4'd3; // Result plus a strobe while busy

  logic                  clk;
  logic                  reset;
  logic                  instr_valid;
  instr_t                instr;
  logic                  busy;
  logic                  result_valid;
  reg_addr_t             result_rd;
  logic [DATA_WIDTH-1:0] result;
  logic                  illegal;

  logic [55:0] vectors [MAX_VECTORS]; // {instr, kind, rd, value}
  logic [15:0] lfsr;
  int          n_pass;
  int          n_fail;
  int          n_errors;
  logic        timed_out;

  simple_processor_top #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .busy_o         (busy),
    .result_valid_o (result_valid),
    .result_rd_o    (result_rd),
    .result_o       (result),
    .illegal_o      (illegal)
  );

  always #5 clk = ~clk; // 10 ns period

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic next_random_bit(output logic rnd);
    rnd  = lfsr[0];
    lfsr = lfsr_next(lfsr); // One step per bit
  endtask

  task automatic idle_gap();
    logic b0;
    logic b1;
    next_random_bit(b0);
    next_random_bit(b1);
    repeat ({b1, b0}) @(posedge clk); // 0 to 3 cycles
  endtask

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      n_errors++;
    end
  endtask

  task automatic wait_idle(output logic ok);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy && cycles < WAIT_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
    ok = !busy;
  endtask

  task automatic wait_response(output logic ok);
    int cycles;
    cycles = 0;
    @(negedge clk); // Outputs sampled mid-cycle
    while (!(result_valid || illegal) && cycles < WAIT_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
    ok = result_valid || illegal;
  endtask

  // One-cycle strobe, accepted on the second edge
  task automatic send_instr(input instr_t word);
    @(posedge clk);
    #1;
    instr_valid = 1'b1;
    instr       = word;
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic run_vector(input int idx, input logic [55:0] vec);
    instr_t      word;
    logic [3:0]  kind;
    logic [3:0]  rd;
    logic [31:0] value;
    logic        ok;
    int          errors_before;
    word          = vec[55:40];
    kind          = vec[39:36];
    rd            = vec[35:32];
    value         = vec[31:0];
    errors_before = n_errors;
    wait_idle(ok);
    if (!ok) begin
      $display("test %0d: timeout, DUT stayed busy before instr %h", idx, word);
      n_fail++;
      timed_out = 1'b1;
      return;
    end
    send_instr(word);
    if (kind == KIND_STRAY) begin
      instr_valid = 1'b1; // Core sits in READ here
      instr       = STRAY_INSTR;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
    end
    wait_response(ok);
    if (!ok) begin
      $display("test %0d: timeout, no result or illegal pulse for instr %h", idx, word);
      n_fail++;
      timed_out = 1'b1;
      return;
    end
    compare_value(illegal, kind == KIND_ILLEGAL, "illegal_o");
    compare_value(result_valid, kind != KIND_ILLEGAL, "result_valid_o");
    if (kind != KIND_ILLEGAL) begin
      compare_value(result_rd, rd, "result_rd_o");
      compare_value(result, value, "result_o");
    end
    compare_value(busy, 1'b1, "busy_o in write cycle");
    // One cycle later the core is idle and the pulse is over
    @(negedge clk);
    compare_value(busy, 1'b0, "busy_o after write");
    compare_value(result_valid || illegal, 1'b0, "pulse after write");
    if (n_errors == errors_before) begin
      n_pass++;
      $display("test %0d: instr %h ok", idx, word);
    end else begin
      n_fail++;
      $display("test %0d: instr %h mismatch", idx, word);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int idx;
    clk         = 1'b0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = LFSR_SEED;
    n_pass      = 0;
    n_fail      = 0;
    n_errors    = 0;
    timed_out   = 1'b0;
    $readmemh("testbench/simple_processor_testdata.txt", vectors);
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    idx   = 0;
    // Stops at the end marker or an unfilled entry
    while (idx < MAX_VECTORS && !timed_out && vectors[idx][39:36] != KIND_END) begin
      run_vector(idx, vectors[idx]);
      idle_gap();
      idx++;
    end
    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_pass + n_fail == 0) $display("no test vectors were run");
    if (n_fail == 0 && n_pass > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/simple_processor_top.sv
`timescale 1ns/100ps
`default_nettype none

module simple_processor_top #(
  parameter int unsigned DATA_WIDTH = simple_processor_pkg::DATA_WIDTH
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            instr_valid_i,
  input  simple_processor_pkg::instr_t    instr_i,
  output logic                            busy_o,
  output logic                            result_valid_o,
  output simple_processor_pkg::reg_addr_t result_rd_o,
  output logic [DATA_WIDTH-1:0]           result_o,
  output logic                            illegal_o
);
  import simple_processor_pkg::*;

  reg_addr_t             rs1_addr;
  reg_addr_t             rs2_addr;
  logic [DATA_WIDTH-1:0] rs1_data;
  logic [DATA_WIDTH-1:0] rs2_data;
  decoded_instr_t        dec;      // Registered decode for the datapath
  logic [DATA_WIDTH-1:0] op_a;
  logic [DATA_WIDTH-1:0] op_b;
  logic [DATA_WIDTH-1:0] exec_result;
  logic                  wr_en;
  reg_addr_t             wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  core_controller #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_core_controller (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .exec_result_i  (exec_result),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .dec_o          (dec),
    .op_a_o         (op_a),
    .op_b_o         (op_b),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_o       (result_o),
    .illegal_o      (illegal_o)
  );

  register_file #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_register_file (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  execution_unit #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_execution_unit (
    .dec_i    (dec),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .result_o (exec_result)
  );

endmodule

`default_nettype wire

//--- design/core_controller.sv
`timescale 1ns/100ps
`default_nettype none

module core_controller #(
  parameter int unsigned DATA_WIDTH = simple_processor_pkg::DATA_WIDTH
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 instr_valid_i,
  input  simple_processor_pkg::instr_t         instr_i,
  input  logic [DATA_WIDTH-1:0]                rs1_data_i,
  input  logic [DATA_WIDTH-1:0]                rs2_data_i,
  input  logic [DATA_WIDTH-1:0]                exec_result_i,
  output simple_processor_pkg::reg_addr_t      rs1_addr_o,
  output simple_processor_pkg::reg_addr_t      rs2_addr_o,
  output simple_processor_pkg::decoded_instr_t dec_o,
  output logic [DATA_WIDTH-1:0]                op_a_o,
  output logic [DATA_WIDTH-1:0]                op_b_o,
  output logic                                 wr_en_o,
  output simple_processor_pkg::reg_addr_t      wr_addr_o,
  output logic [DATA_WIDTH-1:0]                wr_data_o,
  output logic                                 busy_o,
  output logic                                 result_valid_o,
  output simple_processor_pkg::reg_addr_t      result_rd_o,
  output logic [DATA_WIDTH-1:0]                result_o,
  output logic                                 illegal_o
);
  import simple_processor_pkg::*;

  ctrl_state_t           state_q;
  logic                  ops_loaded_q; // Second EXEC cycle
  logic                  accept;
  instr_t                instr_q;
  decoded_instr_t        dec_now;      // Decoder output on held word
  decoded_instr_t        dec_q;
  logic [DATA_WIDTH-1:0] op_a_q;
  logic [DATA_WIDTH-1:0] op_b_q;
  logic [DATA_WIDTH-1:0] result_q;

  assign busy_o = (state_q != IDLE);
  assign accept = instr_valid_i && !busy_o; // Strobes while busy are dropped

  instr_decoder i_instr_decoder (
    .instr_i (instr_q),
    .dec_o   (dec_now)
  );

  assign rs1_addr_o = dec_now.rs1;
  assign rs2_addr_o = dec_now.rs2;

  ////////////////////////////////////////////////////////////
  // Sequencing FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= IDLE;
      ops_loaded_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE:  if (accept) state_q <= READ;
        READ:  state_q <= EXEC;           // Register file address settles
        EXEC: begin
          ops_loaded_q <= !ops_loaded_q;  // Two cycles in EXEC
          if (ops_loaded_q) state_q <= WRITE;
        end
        WRITE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Held instruction word
  always_ff @(posedge clk_i) begin
    if (accept) instr_q <= instr_i;
  end

  // Operands at the end of the first EXEC cycle
  always_ff @(posedge clk_i) begin
    if ((state_q == EXEC) && !ops_loaded_q) begin
      op_a_q <= rs1_data_i;
      op_b_q <= rs2_data_i;
    end
  end

  // Decoded word and result registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_q    <= '0;
      result_q <= '0;
    end else if (state_q == EXEC) begin
      if (!ops_loaded_q) dec_q <= dec_now;
      else               result_q <= exec_result_i; // Execution unit output
    end
  end

  assign dec_o  = dec_q;
  assign op_a_o = op_a_q;
  assign op_b_o = op_b_q;

  ////////////////////////////////////////////////////////////
  // Write back and report
  ////////////////////////////////////////////////////////////

  assign result_valid_o = (state_q == WRITE) && dec_q.legal;
  assign illegal_o      = (state_q == WRITE) && !dec_q.legal;
  assign wr_en_o        = result_valid_o; // Register lands at end of WRITE
  assign wr_addr_o      = dec_q.rd;
  assign wr_data_o      = result_q;
  assign result_rd_o    = dec_q.rd;
  assign result_o       = result_q;

  // Four busy cycles per accepted instruction
  busy_window: assert property (
    @(posedge clk_i) disable iff (reset_i)
    accept |=> busy_o [*4] ##1 !busy_o
  );

endmodule

`default_nettype wire

//--- design/execution_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execution_unit #(
  parameter int unsigned DATA_WIDTH = simple_processor_pkg::DATA_WIDTH
) (
  input  simple_processor_pkg::decoded_instr_t dec_i,
  input  logic [DATA_WIDTH-1:0]                op_a_i,
  input  logic [DATA_WIDTH-1:0]                op_b_i,
  output logic [DATA_WIDTH-1:0]                result_o
);
  import simple_processor_pkg::*;

  localparam int unsigned SHAMT_WIDTH = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0]  imm_ext;     // Sign-extended immediate
  logic [DATA_WIDTH-1:0]  math_b;      // Second adder operand
  logic [DATA_WIDTH-1:0]  res_math;
  logic [DATA_WIDTH-1:0]  res_logic;
  logic [DATA_WIDTH-1:0]  res_shift;
  logic [SHAMT_WIDTH-1:0] shift_amount;
  logic                   shift_right;

  assign imm_ext = {{(DATA_WIDTH-IMM_WIDTH){dec_i.imm[IMM_WIDTH-1]}}, dec_i.imm};

  ////////////////////////////////////////////////////////////
  // Math block
  ////////////////////////////////////////////////////////////

  assign math_b   = dec_i.use_imm ? imm_ext : op_b_i;
  assign res_math = (dec_i.func == SUB) ? op_a_i - op_b_i
                                        : op_a_i + math_b; // ADD and ADDI

  ////////////////////////////////////////////////////////////
  // Logic block
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (dec_i.func)
      AND:     res_logic = op_a_i & op_b_i;
      OR:      res_logic = op_a_i | op_b_i;
      XOR:     res_logic = op_a_i ^ op_b_i;
      NOT:     res_logic = ~op_a_i;         // rs2 ignored
      default: res_logic = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Shift block
  ////////////////////////////////////////////////////////////

  // Only the low bits count, larger amounts wrap
  assign shift_amount = dec_i.use_imm ? imm_ext[SHAMT_WIDTH-1:0]
                                      : op_b_i[SHAMT_WIDTH-1:0];
  assign shift_right  = (dec_i.func == SLR) || (dec_i.func == SLRI);
  assign res_shift    = shift_right ? op_a_i >> shift_amount  // Zero fill
                                    : op_a_i << shift_amount;

  // Result select
  always_comb begin
    case (dec_i.unit_sel)
      UNIT_MATH:  result_o = res_math;
      UNIT_LOGIC: result_o = res_logic;
      UNIT_SHIFT: result_o = res_shift;
      default:    result_o = '0;
    endcase
  end

  // Decoder and controller must hand over a named unit for legal work
  unit_sel_named: assert final (
    !dec_i.legal || (dec_i.unit_sel inside {UNIT_MATH, UNIT_LOGIC, UNIT_SHIFT})
  );

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file #(
  parameter int unsigned DATA_WIDTH = simple_processor_pkg::DATA_WIDTH
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  simple_processor_pkg::reg_addr_t rs1_addr_i,
  input  simple_processor_pkg::reg_addr_t rs2_addr_i,
  input  logic                            wr_en_i,
  input  simple_processor_pkg::reg_addr_t wr_addr_i,
  input  logic [DATA_WIDTH-1:0]           wr_data_i,
  output logic [DATA_WIDTH-1:0]           rs1_data_o,
  output logic [DATA_WIDTH-1:0]           rs2_data_o
);
  import simple_processor_pkg::*;

  localparam int unsigned NUM_REGS = 2 ** REG_ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] regs_q [1:NUM_REGS-1]; // No storage for r0

  // Write port, r0 writes dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i]; // r0 reads zero
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

  // Controller must present a clean index on every write
  wr_addr_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
    wr_en_i |-> !$isunknown(wr_addr_i)
  );

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  simple_processor_pkg::instr_t         instr_i,
  output simple_processor_pkg::decoded_instr_t dec_o
);
  import simple_processor_pkg::*;

  // Field positions
  localparam int unsigned FUNC_LSB = 12;
  localparam int unsigned RD_LSB   = 9;
  localparam int unsigned RS1_LSB  = 6;

  func_t func; // Raw code, may hold an unused value

  assign func = func_t'(instr_i[FUNC_LSB +: 4]);

  always_comb begin
    // Fields are extracted regardless of the function
    dec_o.func     = func;
    dec_o.rd       = instr_i[RD_LSB +: REG_ADDR_WIDTH];
    dec_o.rs1      = instr_i[RS1_LSB +: REG_ADDR_WIDTH];
    dec_o.rs2      = instr_i[REG_ADDR_WIDTH-1:0]; // Overlaps imm low bits
    dec_o.imm      = instr_i[IMM_WIDTH-1:0];
    dec_o.unit_sel = UNIT_MATH;
    dec_o.use_imm  = 1'b0;
    dec_o.legal    = 1'b1;

    ////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////
    case (func)
      ADD, SUB: begin
        dec_o.unit_sel = UNIT_MATH;
      end
      ADDI: begin
        dec_o.unit_sel = UNIT_MATH;
        dec_o.use_imm  = 1'b1;
      end
      AND, OR, XOR, NOT: begin
        dec_o.unit_sel = UNIT_LOGIC; // NOT only looks at rs1
      end
      SLL, SLR: begin
        dec_o.unit_sel = UNIT_SHIFT;
      end
      SLLI, SLRI: begin
        dec_o.unit_sel = UNIT_SHIFT;
        dec_o.use_imm  = 1'b1;
      end
      default: begin
        dec_o.legal = 1'b0; // Unused code, no write
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/simple_processor_pkg.sv
`default_nettype none

package simple_processor_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_WIDTH     = 32; // Default operand width, top overrides
  localparam int unsigned INSTR_WIDTH    = 16;
  localparam int unsigned REG_ADDR_WIDTH = 3;  // Eight registers
  localparam int unsigned IMM_WIDTH      = 6;

  typedef logic [INSTR_WIDTH-1:0]    instr_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Function codes, 4'hB to 4'hF are illegal
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    ADDI = 4'h2,
    AND  = 4'h3,
    OR   = 4'h4,
    XOR  = 4'h5,
    NOT  = 4'h6,
    SLL  = 4'h7,
    SLLI = 4'h8,
    SLR  = 4'h9, // Logical right
    SLRI = 4'hA
  } func_t;

  // Execution block whose result is taken
  typedef enum logic [1:0] {
    UNIT_MATH  = 2'd0,
    UNIT_LOGIC = 2'd1,
    UNIT_SHIFT = 2'd2
  } unit_sel_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    EXEC  = 2'd2,
    WRITE = 2'd3
  } ctrl_state_t;

  typedef struct packed {
    func_t                func;
    unit_sel_t            unit_sel;
    logic                 use_imm;  // Second operand from imm
    reg_addr_t            rd;
    reg_addr_t            rs1;
    reg_addr_t            rs2;
    logic [IMM_WIDTH-1:0] imm;      // Raw field, extended in datapath
    logic                 legal;
  } decoded_instr_t;

endpackage

`default_nettype wire
